// ==== include/aib_params.svh ====
// Single channel AIB leader constants, shared by RTL and testbench
// Pad format is fixed at two DBI lanes of 20 bits each
`ifndef AIB_PARAMS_SVH
`define AIB_PARAMS_SVH

// ------------------------------------------------------------
// Bus and data widths
// ------------------------------------------------------------
`define AIB_ADDR_W      4
`define AIB_REG_W       32
`define AIB_PAD_W       40
// Top bit of each lane is the DBI flag, the rest is payload
`define AIB_LANE_W      20
// Lane 0 takes payload 18:0, lane 1 takes 37:19
`define AIB_PAYLOAD_W   38

// ------------------------------------------------------------
// DBI and bring-up timing
// ------------------------------------------------------------
// Lane inverts when more than this many payload ones
`define AIB_DBI_LIMIT   9
// Cycles between adapter reset release and MAC ready
`define AIB_RSTN_WAIT   4

// ------------------------------------------------------------
// Register contents
// ------------------------------------------------------------
`define AIB_ID_VALUE        32'h0A1B_4C01
`define AIB_CTRL_CONF_BIT   0
`define AIB_CTRL_DBI_BIT    1
`define AIB_CTRL_LPBK_BIT   2

`endif

// ==== logic/aib_pkg.sv ====
// Types shared by the AIB leader modules
// Register addresses double as the bus opcodes
`default_nettype none

`include "aib_params.svh"

package aib_pkg;

    // Bring-up states, codes are visible in STATUS[2:0]
    typedef enum logic [2:0] {
        ST_WAIT_CONF = 3'd0,
        ST_ADAPT_RST = 3'd1,
        ST_MAC_RDY   = 3'd2,
        ST_DLL_LOCK  = 3'd3,
        ST_XFER      = 3'd4
    } link_state_e;

    // Register map
    typedef enum logic [`AIB_ADDR_W-1:0] {
        REG_CTRL   = `AIB_ADDR_W'd0,
        REG_STATUS = `AIB_ADDR_W'd1,
        REG_ID     = `AIB_ADDR_W'd2
    } cfg_reg_e;

endpackage

`default_nettype wire

// ==== logic/aib_cfg_decode.sv ====
// Register block on a strobe bus with no wait states
// Read data is valid one cycle after the read strobe; STATUS and ID are read only
`timescale 1ns/1ps
`default_nettype none

`include "aib_params.svh"

module aib_cfg_decode (
    input  logic                    intf_m1,
    input  logic                    i_rst_n,
    input  logic [`AIB_ADDR_W-1:0]  i_cfg_addr,
    input  logic                    i_cfg_write,
    input  logic                    i_cfg_read,
    input  logic [`AIB_REG_W-1:0]   i_cfg_wdata,
    input  aib_pkg::link_state_e    i_link_state,
    input  logic                    i_tx_xfer_en,
    input  logic                    i_rx_xfer_en,
    output logic [`AIB_REG_W-1:0]   o_cfg_rdata,
    output logic                    o_cfg_rdatavld,
    output logic                    o_conf_done,
    output logic                    o_dbi_en,
    output logic                    o_lpbk
);

    aib_pkg::cfg_reg_e       addr_sel;
    logic                    conf_done_q;
    logic                    dbi_en_q;
    logic                    lpbk_q;
    logic [`AIB_REG_W-1:0]   rd_mux;
    logic [`AIB_REG_W-1:0]   rdata_q;
    logic                    rdatavld_q;

    assign addr_sel = aib_pkg::cfg_reg_e'(i_cfg_addr);

    // ------------------------------------------------------------
    // CTRL register
    // ------------------------------------------------------------
    always_ff @(posedge intf_m1) begin
        if (!i_rst_n) begin
            conf_done_q <= 1'b0;
            dbi_en_q    <= 1'b0;
            lpbk_q      <= 1'b0;
        end else if (i_cfg_write && addr_sel == aib_pkg::REG_CTRL) begin
            conf_done_q <= i_cfg_wdata[`AIB_CTRL_CONF_BIT];
            dbi_en_q    <= i_cfg_wdata[`AIB_CTRL_DBI_BIT];
            lpbk_q      <= i_cfg_wdata[`AIB_CTRL_LPBK_BIT];
        end
    end

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    always_comb begin
        rd_mux = '0;
        case (addr_sel)
            aib_pkg::REG_CTRL: begin
                rd_mux[`AIB_CTRL_CONF_BIT] = conf_done_q;
                rd_mux[`AIB_CTRL_DBI_BIT]  = dbi_en_q;
                rd_mux[`AIB_CTRL_LPBK_BIT] = lpbk_q;
            end
            aib_pkg::REG_STATUS: begin
                // State code, then the two transfer enables
                rd_mux[2:0] = i_link_state;
                rd_mux[4]   = i_tx_xfer_en;
                rd_mux[5]   = i_rx_xfer_en;
            end
            aib_pkg::REG_ID: rd_mux = `AIB_ID_VALUE;
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge intf_m1) begin
        if (i_cfg_read) begin
            rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge intf_m1) begin
        if (!i_rst_n) begin
            rdatavld_q <= 1'b0;
        end else begin
            rdatavld_q <= i_cfg_read;
        end
    end

    assign o_cfg_rdata    = rdata_q;
    assign o_cfg_rdatavld = rdatavld_q;
    assign o_conf_done    = conf_done_q;
    assign o_dbi_en       = dbi_en_q;
    assign o_lpbk         = lpbk_q;

    // Back-to-back valid only for back-to-back strobes
    a_rdatavld_single : assert property (
        @(posedge intf_m1) disable iff (!i_rst_n)
        (rdatavld_q && $past(rdatavld_q)) |-> $past(i_cfg_read, 1) && $past(i_cfg_read, 2)
    );

endmodule

`default_nettype wire

// ==== logic/aib_link_seq.sv ====
// Leader bring-up sequencer; far-side inputs are levels already in intf_m1
// Losing conf_done or device detect drops the link within one edge
`timescale 1ns/1ps
`default_nettype none

`include "aib_params.svh"

module aib_link_seq (
    input  logic                  intf_m1,
    input  logic                  i_rst_n,
    input  logic                  i_conf_done,
    input  logic                  i_device_detect,
    input  logic                  i_fs_mac_rdy,
    input  logic                  i_fs_dll_lock,
    output aib_pkg::link_state_e  o_link_state,
    output logic                  o_ns_adapter_rstn,
    output logic                  o_ns_mac_rdy,
    output logic                  o_dll_lock_req,
    output logic                  o_ms_tx_transfer_en,
    output logic                  o_ms_rx_transfer_en
);

    localparam int CNT_W = $clog2(`AIB_RSTN_WAIT + 1);

    aib_pkg::link_state_e  state_q;
    aib_pkg::link_state_e  state_d;
    logic [CNT_W-1:0]      wait_cnt_q;
    logic                  link_ok;
    logic                  rstn_q;
    logic                  mac_rdy_q;
    logic                  lock_req_q;
    logic                  xfer_q;

    assign link_ok = i_conf_done && i_device_detect;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        if (!link_ok) begin
            state_d = aib_pkg::ST_WAIT_CONF;
        end else begin
            case (state_q)
                aib_pkg::ST_WAIT_CONF: state_d = aib_pkg::ST_ADAPT_RST;
                aib_pkg::ST_ADAPT_RST: begin
                    if (wait_cnt_q == CNT_W'(`AIB_RSTN_WAIT - 1)) begin
                        state_d = aib_pkg::ST_MAC_RDY;
                    end
                end
                aib_pkg::ST_MAC_RDY: begin
                    if (i_fs_mac_rdy) begin
                        state_d = aib_pkg::ST_DLL_LOCK;
                    end
                end
                aib_pkg::ST_DLL_LOCK: begin
                    if (i_fs_dll_lock) begin
                        state_d = aib_pkg::ST_XFER;
                    end
                end
                aib_pkg::ST_XFER: state_d = aib_pkg::ST_XFER;
                default:          state_d = aib_pkg::ST_WAIT_CONF;
            endcase
        end
    end

    // ------------------------------------------------------------
    // State, wait counter and registered outputs
    // ------------------------------------------------------------
    always_ff @(posedge intf_m1) begin
        if (!i_rst_n) begin
            state_q    <= aib_pkg::ST_WAIT_CONF;
            wait_cnt_q <= '0;
            rstn_q     <= 1'b0;
            mac_rdy_q  <= 1'b0;
            lock_req_q <= 1'b0;
            xfer_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            // Counts cycles spent in ST_ADAPT_RST, idles at zero elsewhere
            if (state_q == aib_pkg::ST_ADAPT_RST && link_ok) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end else begin
                wait_cnt_q <= '0;
            end
            // Outputs follow the state entered on this edge
            rstn_q     <= (state_d != aib_pkg::ST_WAIT_CONF);
            mac_rdy_q  <= state_d inside {aib_pkg::ST_MAC_RDY, aib_pkg::ST_DLL_LOCK,
                                          aib_pkg::ST_XFER};
            lock_req_q <= state_d inside {aib_pkg::ST_DLL_LOCK, aib_pkg::ST_XFER};
            xfer_q     <= (state_d == aib_pkg::ST_XFER);
        end
    end

    assign o_link_state        = state_q;
    assign o_ns_adapter_rstn   = rstn_q;
    assign o_ns_mac_rdy        = mac_rdy_q;
    assign o_dll_lock_req      = lock_req_q;
    assign o_ms_tx_transfer_en = xfer_q;
    assign o_ms_rx_transfer_en = xfer_q;

    a_xfer_needs_mac_rdy : assert property (
        @(posedge intf_m1) disable iff (!i_rst_n)
        (o_ms_tx_transfer_en || o_ms_rx_transfer_en) |-> o_ns_mac_rdy
    );

    // No progress out of reset wait without conf_done
    a_hold_wait_conf : assert property (
        @(posedge intf_m1) disable iff (!i_rst_n)
        (state_q == aib_pkg::ST_WAIT_CONF && !i_conf_done) |=>
            (state_q == aib_pkg::ST_WAIT_CONF)
    );

endmodule

`default_nettype wire

// ==== logic/aib_tx_encode.sv ====
// Transmit path with per-lane DBI, one cycle to the pad register
// Words offered while transfer is disabled are dropped, no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "aib_params.svh"

module aib_tx_encode (
    input  logic                        intf_m1,
    input  logic                        i_rst_n,
    input  logic [`AIB_PAYLOAD_W-1:0]   i_tx_data,
    input  logic                        i_tx_valid,
    input  logic                        i_tx_xfer_en,
    input  logic                        i_dbi_en,
    output logic [`AIB_PAD_W-1:0]       o_pad_data,
    output logic                        o_pad_valid
);

    localparam int LANE_PL   = `AIB_LANE_W - 1;
    localparam int NUM_LANES = `AIB_PAD_W / `AIB_LANE_W;

    logic [`AIB_PAD_W-1:0]  pad_d;
    logic [`AIB_PAD_W-1:0]  pad_q;
    logic                   pad_valid_q;
    logic                   accept;

    // Lane encode, flag goes in the top bit of each lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        logic [LANE_PL-1:0] pl;
        logic               inv;

        assign pl  = i_tx_data[g*LANE_PL +: LANE_PL];
        assign inv = i_dbi_en && ($countones(pl) > `AIB_DBI_LIMIT);
        assign pad_d[g*`AIB_LANE_W +: `AIB_LANE_W] = {inv, inv ? ~pl : pl};
    end

    assign accept = i_tx_valid && i_tx_xfer_en;

    always_ff @(posedge intf_m1) begin
        if (accept) begin
            pad_q <= pad_d;
        end
    end

    always_ff @(posedge intf_m1) begin
        if (!i_rst_n) begin
            pad_valid_q <= 1'b0;
        end else begin
            pad_valid_q <= accept;
        end
    end

    assign o_pad_data  = pad_q;
    assign o_pad_valid = pad_valid_q;

    a_pad_valid_enabled : assert property (
        @(posedge intf_m1) disable iff (!i_rst_n)
        o_pad_valid |-> $past(i_tx_xfer_en)
    );

endmodule

`default_nettype wire

// ==== logic/aib_rx_decode.sv ====
// Receive path, loopback select and DBI decode, one cycle to output
// Lane flags are honoured regardless of the local DBI enable
`timescale 1ns/1ps
`default_nettype none

`include "aib_params.svh"

module aib_rx_decode (
    input  logic                        intf_m1,
    input  logic                        i_rst_n,
    input  logic [`AIB_PAD_W-1:0]       i_pad_rx_data,
    input  logic                        i_pad_rx_valid,
    input  logic [`AIB_PAD_W-1:0]       i_lpbk_data,
    input  logic                        i_lpbk_valid,
    input  logic                        i_lpbk,
    input  logic                        i_rx_xfer_en,
    output logic [`AIB_PAYLOAD_W-1:0]   o_rx_data,
    output logic                        o_rx_valid
);

    localparam int LANE_PL   = `AIB_LANE_W - 1;
    localparam int NUM_LANES = `AIB_PAD_W / `AIB_LANE_W;

    logic [`AIB_PAD_W-1:0]      src_data;
    logic                       src_valid;
    logic [`AIB_PAYLOAD_W-1:0]  rx_d;
    logic [`AIB_PAYLOAD_W-1:0]  rx_q;
    logic                       rx_valid_q;

    // Near-side loopback takes our own pad word
    assign src_data  = i_lpbk ? i_lpbk_data  : i_pad_rx_data;
    assign src_valid = i_lpbk ? i_lpbk_valid : i_pad_rx_valid;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        logic [LANE_PL-1:0] pl;
        logic               flag;

        assign pl   = src_data[g*`AIB_LANE_W +: LANE_PL];
        assign flag = src_data[g*`AIB_LANE_W + LANE_PL];
        assign rx_d[g*LANE_PL +: LANE_PL] = flag ? ~pl : pl;
    end

    always_ff @(posedge intf_m1) begin
        if (src_valid && i_rx_xfer_en) begin
            rx_q <= rx_d;
        end
    end

    always_ff @(posedge intf_m1) begin
        if (!i_rst_n) begin
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= src_valid && i_rx_xfer_en;
        end
    end

    assign o_rx_data  = rx_q;
    assign o_rx_valid = rx_valid_q;

endmodule

`default_nettype wire

// ==== logic/aib_leader_top.sv ====
// Single channel AIB leader adapter, all logic on intf_m1
// Loopback path is o_rx_data two cycles after i_tx_data
`timescale 1ns/1ps
`default_nettype none

`include "aib_params.svh"

module aib_leader_top (
    input  logic                        intf_m1,
    input  logic                        i_rst_n,
    // Register bus
    input  logic [`AIB_ADDR_W-1:0]      i_cfg_addr,
    input  logic                        i_cfg_write,
    input  logic                        i_cfg_read,
    input  logic [`AIB_REG_W-1:0]       i_cfg_wdata,
    output logic [`AIB_REG_W-1:0]       o_cfg_rdata,
    output logic                        o_cfg_rdatavld,
    // Far side and link control
    input  logic                        i_device_detect,
    input  logic                        i_fs_mac_rdy,
    input  logic                        i_fs_dll_lock,
    output logic                        o_ns_adapter_rstn,
    output logic                        o_ns_mac_rdy,
    output logic                        o_dll_lock_req,
    output logic                        o_ms_tx_transfer_en,
    output logic                        o_ms_rx_transfer_en,
    // Data
    input  logic [`AIB_PAYLOAD_W-1:0]   i_tx_data,
    input  logic                        i_tx_valid,
    output logic [`AIB_PAD_W-1:0]       o_pad_data,
    output logic                        o_pad_valid,
    input  logic [`AIB_PAD_W-1:0]       i_pad_rx_data,
    input  logic                        i_pad_rx_valid,
    output logic [`AIB_PAYLOAD_W-1:0]   o_rx_data,
    output logic                        o_rx_valid
);

    aib_pkg::link_state_e  link_state;
    logic                  conf_done;
    logic                  dbi_en;
    logic                  lpbk;

    aib_cfg_decode u_cfg_decode (
        .intf_m1        (intf_m1),
        .i_rst_n        (i_rst_n),
        .i_cfg_addr     (i_cfg_addr),
        .i_cfg_write    (i_cfg_write),
        .i_cfg_read     (i_cfg_read),
        .i_cfg_wdata    (i_cfg_wdata),
        .i_link_state   (link_state),
        .i_tx_xfer_en   (o_ms_tx_transfer_en),
        .i_rx_xfer_en   (o_ms_rx_transfer_en),
        .o_cfg_rdata    (o_cfg_rdata),
        .o_cfg_rdatavld (o_cfg_rdatavld),
        .o_conf_done    (conf_done),
        .o_dbi_en       (dbi_en),
        .o_lpbk         (lpbk)
    );

    aib_link_seq u_link_seq (
        .intf_m1             (intf_m1),
        .i_rst_n             (i_rst_n),
        .i_conf_done         (conf_done),
        .i_device_detect     (i_device_detect),
        .i_fs_mac_rdy        (i_fs_mac_rdy),
        .i_fs_dll_lock       (i_fs_dll_lock),
        .o_link_state        (link_state),
        .o_ns_adapter_rstn   (o_ns_adapter_rstn),
        .o_ns_mac_rdy        (o_ns_mac_rdy),
        .o_dll_lock_req      (o_dll_lock_req),
        .o_ms_tx_transfer_en (o_ms_tx_transfer_en),
        .o_ms_rx_transfer_en (o_ms_rx_transfer_en)
    );

    aib_tx_encode u_tx_encode (
        .intf_m1      (intf_m1),
        .i_rst_n      (i_rst_n),
        .i_tx_data    (i_tx_data),
        .i_tx_valid   (i_tx_valid),
        .i_tx_xfer_en (o_ms_tx_transfer_en),
        .i_dbi_en     (dbi_en),
        .o_pad_data   (o_pad_data),
        .o_pad_valid  (o_pad_valid)
    );

    // Pad outputs loop back into the receive side
    aib_rx_decode u_rx_decode (
        .intf_m1        (intf_m1),
        .i_rst_n        (i_rst_n),
        .i_pad_rx_data  (i_pad_rx_data),
        .i_pad_rx_valid (i_pad_rx_valid),
        .i_lpbk_data    (o_pad_data),
        .i_lpbk_valid   (o_pad_valid),
        .i_lpbk         (lpbk),
        .i_rx_xfer_en   (o_ms_rx_transfer_en),
        .o_rx_data      (o_rx_data),
        .o_rx_valid     (o_rx_valid)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// Testbench clock of 8 ns period and a reset held low for 4 rising edges
// Reset is released 1 ns after an edge, in step with the other stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_aib_leader.sv ====
// Testbench for the AIB leader, commands come from sim/aib_stimulus.mem
// Run from the project root; random payloads use a fixed xorshift seed
`timescale 1ns/1ps
`default_nettype none

`include "aib_params.svh"

module tb_aib_leader;

    localparam int MAX_CMDS = 64;
    localparam int LANE_PL  = `AIB_LANE_W - 1;
    localparam int N_LANES  = `AIB_PAD_W / `AIB_LANE_W;

    logic                        intf_m1;
    logic                        rst_n;
    logic [`AIB_ADDR_W-1:0]      cfg_addr;
    logic                        cfg_write;
    logic                        cfg_read;
    logic [`AIB_REG_W-1:0]       cfg_wdata;
    logic [`AIB_REG_W-1:0]       cfg_rdata;
    logic                        cfg_rdatavld;
    logic                        device_detect;
    logic                        fs_mac_rdy;
    logic                        fs_dll_lock;
    logic                        ns_adapter_rstn;
    logic                        ns_mac_rdy;
    logic                        dll_lock_req;
    logic                        tx_xfer_en;
    logic                        rx_xfer_en;
    logic [`AIB_PAYLOAD_W-1:0]   tx_data;
    logic                        tx_valid;
    logic [`AIB_PAD_W-1:0]       pad_data;
    logic                        pad_valid;
    logic [`AIB_PAD_W-1:0]       pad_rx_data;
    logic                        pad_rx_valid;
    logic [`AIB_PAYLOAD_W-1:0]   rx_data;
    logic                        rx_valid;

    logic [63:0]  stim_mem [0:3*MAX_CMDS-1];
    logic [31:0]  rng_state = 32'h2fb7_d1ab;
    logic [2:0]   ctrl_shadow = 3'b000;
    int           num_cmds;
    int           cycle_count = 0;
    int           cycle_limit = 20 * MAX_CMDS + 200;
    int           error_count = 0;

    tb_clk_gen u_clk_gen (.o_clk(intf_m1), .o_rst_n(rst_n));

    aib_leader_top UUT (
        .intf_m1(intf_m1), .i_rst_n(rst_n),
        .i_cfg_addr(cfg_addr), .i_cfg_write(cfg_write), .i_cfg_read(cfg_read),
        .i_cfg_wdata(cfg_wdata), .o_cfg_rdata(cfg_rdata), .o_cfg_rdatavld(cfg_rdatavld),
        .i_device_detect(device_detect), .i_fs_mac_rdy(fs_mac_rdy),
        .i_fs_dll_lock(fs_dll_lock), .o_ns_adapter_rstn(ns_adapter_rstn),
        .o_ns_mac_rdy(ns_mac_rdy), .o_dll_lock_req(dll_lock_req),
        .o_ms_tx_transfer_en(tx_xfer_en), .o_ms_rx_transfer_en(rx_xfer_en),
        .i_tx_data(tx_data), .i_tx_valid(tx_valid),
        .o_pad_data(pad_data), .o_pad_valid(pad_valid),
        .i_pad_rx_data(pad_rx_data), .i_pad_rx_valid(pad_rx_valid),
        .o_rx_data(rx_data), .o_rx_valid(rx_valid)
    );

    // ------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lane inverts when its payload ones exceed the limit
    function automatic logic [`AIB_PAD_W-1:0] dbi_encode(
        input logic [`AIB_PAYLOAD_W-1:0] data, input logic dbi_on);
        logic [`AIB_PAD_W-1:0]  pad;
        logic [LANE_PL-1:0]     lane;
        int                     ones;
        pad = '0;
        for (int l = 0; l < N_LANES; l++) begin
            lane = data[l*LANE_PL +: LANE_PL];
            ones = 0;
            for (int b = 0; b < LANE_PL; b++) begin
                if (lane[b]) ones++;
            end
            if (dbi_on && ones > `AIB_DBI_LIMIT) begin
                pad[l*`AIB_LANE_W +: `AIB_LANE_W] = {1'b1, ~lane};
            end else begin
                pad[l*`AIB_LANE_W +: `AIB_LANE_W] = {1'b0, lane};
            end
        end
        return pad;
    endfunction

    task automatic next_payload(output logic [`AIB_PAYLOAD_W-1:0] p);
        logic [31:0] hi;
        rng_state = xorshift32(rng_state);
        hi = rng_state;
        rng_state = xorshift32(rng_state);
        p = {hi[`AIB_PAYLOAD_W-33:0], rng_state};
    endtask

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Inputs change 1 ns after the edge, outputs are read there too
    task automatic step();
        @(posedge intf_m1);
        #1;
    endtask

    task automatic send_random_burst(input int count);
        logic [`AIB_PAYLOAD_W-1:0]  sent [$];
        logic [`AIB_PAYLOAD_W-1:0]  word;
        for (int j = 0; j <= count; j++) begin
            tx_valid = (j < count);
            if (j < count) begin
                next_payload(word);
                tx_data = word;
                sent.push_back(word);
            end
            step();
            check_value(64'(pad_valid), 64'(j < count), "pad valid in burst");
            if (j < count) begin
                check_value(64'(pad_data),
                            64'(dbi_encode(sent[j], ctrl_shadow[`AIB_CTRL_DBI_BIT])),
                            "pad word encoding");
            end
            // Loopback adds one more register stage
            if (ctrl_shadow[`AIB_CTRL_LPBK_BIT] && j >= 1) begin
                check_value(64'(rx_valid), 64'd1, "loopback rx valid");
                check_value(64'(rx_data), 64'(sent[j-1]), "loopback rx data");
            end
        end
    endtask

    task automatic run_command(input logic [7:0] kind, input logic [63:0] arg,
                               input logic [63:0] exp);
        case (kind)
            8'h1: begin
                cfg_addr  = arg[`AIB_ADDR_W-1:0];
                cfg_wdata = exp[`AIB_REG_W-1:0];
                cfg_write = 1'b1;
                if (arg == 64'd0) ctrl_shadow = exp[2:0];
                step();
                cfg_write = 1'b0;
            end
            8'h2: begin
                cfg_addr = arg[`AIB_ADDR_W-1:0];
                cfg_read = 1'b1;
                step();
                cfg_read = 1'b0;
                check_value(64'(cfg_rdatavld), 64'd1, "read valid after strobe");
                check_value(64'(cfg_rdata), exp, "register read data");
                step();
                check_value(64'(cfg_rdatavld), 64'd0, "read valid lasts one cycle");
            end
            8'h3: begin
                {fs_dll_lock, fs_mac_rdy, device_detect} = arg[2:0];
                step();
            end
            8'h4: begin
                tx_data  = arg[`AIB_PAYLOAD_W-1:0];
                tx_valid = 1'b1;
                step();
                tx_valid = 1'b0;
                check_value(64'(pad_valid), 64'd1, "pad valid for tx word");
                check_value(64'(pad_data), exp, "pad word");
            end
            8'h5: send_random_burst(int'(arg[7:0]));
            8'h6: begin
                pad_rx_data  = arg[`AIB_PAD_W-1:0];
                pad_rx_valid = 1'b1;
                step();
                pad_rx_valid = 1'b0;
                check_value(64'(rx_valid), 64'd1, "rx valid for pad word");
                check_value(64'(rx_data), exp, "decoded rx payload");
            end
            8'h7: begin
                repeat (int'(arg[7:0])) step();
                check_value(64'({rx_xfer_en, tx_xfer_en, dll_lock_req, ns_mac_rdy,
                                 ns_adapter_rstn}), exp, "link outputs");
            end
            8'h8: begin
                tx_data  = arg[`AIB_PAYLOAD_W-1:0];
                tx_valid = 1'b1;
                step();
                tx_valid = 1'b0;
                check_value(64'(pad_valid), 64'd0, "word dropped without transfer");
            end
            default: begin
                $display("Stimulus file holds an unknown command kind %h", kind);
                stop_with_failure();
            end
        endcase
    endtask

    // ------------------------------------------------------------
    // Timeout and main sequence
    // ------------------------------------------------------------
    always @(posedge intf_m1) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        cfg_addr      = '0;
        cfg_write     = 1'b0;
        cfg_read      = 1'b0;
        cfg_wdata     = '0;
        device_detect = 1'b0;
        fs_mac_rdy    = 1'b0;
        fs_dll_lock   = 1'b0;
        tx_data       = '0;
        tx_valid      = 1'b0;
        pad_rx_data   = '0;
        pad_rx_valid  = 1'b0;
        for (int i = 0; i < 3 * MAX_CMDS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("sim/aib_stimulus.mem", stim_mem);
        num_cmds = 0;
        while (num_cmds < MAX_CMDS && stim_mem[3*num_cmds] != 64'd0) begin
            num_cmds++;
        end
        if (num_cmds == 0) begin
            $display("The stimulus file could not be read or holds no commands");
            stop_with_failure();
        end
        cycle_limit = 20 * num_cmds + 200;
        wait (rst_n === 1'b1);
        for (int c = 0; c < num_cmds; c++) begin
            run_command(stim_mem[3*c][7:0], stim_mem[3*c+1], stim_mem[3*c+2]);
        end
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== sim/aib_stimulus.mem ====
// Columns: kind argument expected, all hex. Kinds: 1 write addr/data, 2 read addr/data,
// 3 far side {lock,mac,detect}, 4 tx word/pad, 5 random burst count, 6 rx pad/payload,
// 7 wait cycles then link outputs {rx_en,tx_en,lock_req,mac_rdy,rstn}, 8 dropped tx word
7 0 00
2 2 0A1B4C01
2 1 00000000
1 0 00000007
2 0 00000007
2 5 00000000
1 0 00000000
3 1 0
1 0 00000001
7 0 00
7 1 01
7 3 01
7 1 03
2 1 00000002
3 3 0
7 0 07
3 7 0
7 0 1F
2 1 00000034
1 0 00000003
4 3FFFFFFFFF 8000080000
4 1FF801FF FFC00001FF
5 C 0
1 0 00000001
4 3FFFFFFFFF 7FFFF7FFFF
5 C 0
1 0 00000007
5 C 0
1 0 00000005
5 C 0
1 0 00000003
6 8000080000 3FFFFFFFFF
6 0000012345 00012345
6 0000380001 001FFFFE
3 6 0
7 0 00
8 155555555 0
2 1 00000000
0 0 0

// ==== flist.f ====
+incdir+include
logic/aib_pkg.sv
logic/aib_cfg_decode.sv
logic/aib_link_seq.sv
logic/aib_tx_encode.sv
logic/aib_rx_decode.sv
logic/aib_leader_top.sv
sim/tb_clk_gen.sv
sim/tb_aib_leader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AIB leader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_aib_leader -o tb_sim

out=$(./obj_dir/tb_sim) || true
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi
